//--- mini_soc_pkg.sv
// Shared definitions for the memory-side harness
// Address map, bus widths, response and target codes, and the request
// address union that the two pipeline stages decode
package mini_soc_pkg;

  // --------------------
  // Widths
  // --------------------
  localparam int unsigned AddrWidth    = 32;
  localparam int unsigned DataWidth    = 64;
  localparam int unsigned BeWidth      = DataWidth / 8;
  localparam int unsigned DramWords    = 8192;
  localparam int unsigned RomWords     = 32;
  localparam int unsigned WordIdxWidth = $clog2(DramWords);
  localparam int unsigned RomIdxWidth  = $clog2(RomWords);
  localparam int unsigned OffsetWidth  = $clog2(BeWidth);
  localparam int unsigned RegionWidth  = AddrWidth - WordIdxWidth - OffsetWidth;
  localparam int unsigned RespWidth    = 2;
  localparam int unsigned TgtWidth     = 2;

  // --------------------
  // Address map
  // --------------------
  localparam logic [AddrWidth-1:0]   RomBase    = 32'h0001_0000;
  localparam logic [AddrWidth-1:0]   DramBase   = 32'h8000_0000;
  localparam logic [RegionWidth-1:0] RomRegion  = RomBase[AddrWidth-1:AddrWidth-RegionWidth];
  localparam logic [RegionWidth-1:0] DramRegion = DramBase[AddrWidth-1:AddrWidth-RegionWidth];

  // Response codes, AXI encoding
  localparam logic [RespWidth-1:0] RespOkay   = 2'd0;
  localparam logic [RespWidth-1:0] RespSlvErr = 2'd2;
  localparam logic [RespWidth-1:0] RespDecErr = 2'd3;

  // Target selected by stage 1
  localparam logic [TgtWidth-1:0] TgtNone = 2'd0;
  localparam logic [TgtWidth-1:0] TgtRom  = 2'd1;
  localparam logic [TgtWidth-1:0] TgtDram = 2'd2;

  // Boot window before debug requests reach the core
  localparam int unsigned DebugHoldCycles = 500;
  localparam int unsigned DebugCntWidth   = $clog2(DebugHoldCycles + 1);

  typedef struct packed {
    logic [RegionWidth-1:0]  region;
    logic [WordIdxWidth-1:0] word_idx;
    logic [OffsetWidth-1:0]  offset;
  } addr_fields_t;

  // Byte address and its region / word / byte split
  typedef union packed {
    logic [AddrWidth-1:0] flat;
    addr_fields_t         fields;
  } addr_u;

endpackage

//--- rst_sync.sv
// Core reset generator
// Merges power-on reset with the non-debug reset request. Assertion is
// asynchronous, release comes on the second clock edge after both clear
module rst_sync (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic ndmreset_i,
  output logic rst_no
);

  logic merged_rst_n;
  logic sync_q1;
  logic sync_q2;

  assign merged_rst_n = rst_ni & ~ndmreset_i;

  // Two-flop release synchroniser
  always_ff @(posedge clk_i or negedge merged_rst_n) begin
    if (!merged_rst_n) begin
      sync_q1 <= 1'b0;
      sync_q2 <= 1'b0;
    end else begin
      sync_q1 <= 1'b1;
      sync_q2 <= sync_q1;
    end
  end

  assign rst_no = sync_q2;

  // Core held in reset for the whole ndmreset request
  a_ndmreset_holds: assert property (
    @(posedge clk_i) disable iff (!rst_ni) ndmreset_i |-> !rst_no
  ) else $error("core reset released during ndmreset request");

endmodule

//--- debug_gate.sv
// Debug request gate
// Blocks debug requests for a fixed boot window after power-on reset so
// the core can run its boot code first. Only power-on reset restarts it
module debug_gate (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic debug_req_i,
  output logic debug_req_o
);

  import mini_soc_pkg::*;

  logic [DebugCntWidth-1:0] cnt_d;
  logic [DebugCntWidth-1:0] cnt_q;

  // Count down and stick at zero
  assign cnt_d = (cnt_q != '0) ? cnt_q - 1'b1 : cnt_q;

  assign debug_req_o = (cnt_q == '0) ? debug_req_i : 1'b0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= DebugCntWidth'(DebugHoldCycles);
    end else begin
      cnt_q <= cnt_d;
    end
  end

  // --------------------
  // Checks
  // --------------------
  a_no_debug_in_window: assert property (
    @(posedge clk_i) disable iff (!rst_ni) (cnt_q != '0) |-> !debug_req_o
  ) else $error("debug request leaked during boot window");

endmodule

//--- req_decode.sv
// Pipeline stage 1
// Registers an incoming request and classifies it against the address map
// into a target and a response status for stage 2
module req_decode (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 req_i,
  input  logic                                 we_i,
  input  mini_soc_pkg::addr_u                  addr_i,
  input  logic [mini_soc_pkg::BeWidth-1:0]     be_i,
  input  logic [mini_soc_pkg::DataWidth-1:0]   wdata_i,
  output logic                                 valid_o,
  output logic                                 we_o,
  output logic [mini_soc_pkg::TgtWidth-1:0]    target_o,
  output logic [mini_soc_pkg::RespWidth-1:0]   status_o,
  output mini_soc_pkg::addr_u                  addr_o,
  output logic [mini_soc_pkg::BeWidth-1:0]     be_o,
  output logic [mini_soc_pkg::DataWidth-1:0]   wdata_o
);

  import mini_soc_pkg::*;

  logic [TgtWidth-1:0]  target_d;
  logic [RespWidth-1:0] status_d;

  logic                 valid_q;
  logic                 we_q;
  logic [TgtWidth-1:0]  target_q;
  logic [RespWidth-1:0] status_q;
  addr_u                addr_q;
  logic [BeWidth-1:0]   be_q;
  logic [DataWidth-1:0] wdata_q;

  // --------------------
  // Region decode
  // --------------------
  always_comb begin
    target_d = TgtNone;
    status_d = RespDecErr;
    case (addr_i.fields.region)
      RomRegion: begin
        target_d = TgtRom;
        // ROM is read-only
        status_d = we_i ? RespSlvErr : RespOkay;
      end
      DramRegion: begin
        target_d = TgtDram;
        status_d = RespOkay;
      end
      default: begin
        target_d = TgtNone;
        status_d = RespDecErr;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q  <= 1'b0;
      target_q <= TgtNone;
      status_q <= RespOkay;
    end else begin
      valid_q  <= req_i;
      target_q <= target_d;
      status_q <= status_d;
    end
  end

  // Request payload
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      we_q    <= we_i;
      addr_q  <= addr_i;
      be_q    <= be_i;
      wdata_q <= wdata_i;
    end
  end

  assign valid_o  = valid_q;
  assign we_o     = we_q;
  assign target_o = target_q;
  assign status_o = status_q;
  assign addr_o   = addr_q;
  assign be_o     = be_q;
  assign wdata_o  = wdata_q;

  a_addr_known: assert property (
    @(posedge clk_i) disable iff (!rst_ni) req_i |-> !$isunknown(addr_i.flat)
  ) else $error("request with unknown address bits");

endmodule

//--- data_sram.sv
// Byte-enabled data memory
// Combinational read of the addressed word, write of the enabled bytes on
// the rising clock edge. Contents are never reset
module data_sram (
  input  logic                                  clk_i,
  input  logic                                  we_i,
  input  logic [mini_soc_pkg::WordIdxWidth-1:0] addr_i,
  input  logic [mini_soc_pkg::BeWidth-1:0]      be_i,
  input  logic [mini_soc_pkg::DataWidth-1:0]    wdata_i,
  output logic [mini_soc_pkg::DataWidth-1:0]    rdata_o
);

  import mini_soc_pkg::*;

  logic [DataWidth-1:0] mem_q [DramWords];

  // --------------------
  // Write port
  // --------------------
  always_ff @(posedge clk_i) begin
    if (we_i) begin
      for (int unsigned b = 0; b < BeWidth; b++) begin
        if (be_i[b]) begin
          mem_q[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
        end
      end
    end
  end

  // --------------------
  // Read port
  // --------------------
  assign rdata_o = mem_q[addr_i];

endmodule

//--- mem_access.sv
// Pipeline stage 2
// Reads the boot ROM, reads or writes the data SRAM, and registers the
// response. Errors and writes respond with zero data
module mem_access (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 valid_i,
  input  logic                                 we_i,
  input  logic [mini_soc_pkg::TgtWidth-1:0]    target_i,
  input  logic [mini_soc_pkg::RespWidth-1:0]   status_i,
  input  mini_soc_pkg::addr_u                  addr_i,
  input  logic [mini_soc_pkg::BeWidth-1:0]     be_i,
  input  logic [mini_soc_pkg::DataWidth-1:0]   wdata_i,
  output logic                                 rsp_valid_o,
  output logic [mini_soc_pkg::RespWidth-1:0]   rsp_status_o,
  output logic [mini_soc_pkg::DataWidth-1:0]   rdata_o
);

  import mini_soc_pkg::*;

  logic [DataWidth-1:0]   rom_mem [RomWords];
  logic [RomIdxWidth-1:0] rom_idx;
  logic [DataWidth-1:0]   rom_rdata;
  logic [DataWidth-1:0]   sram_rdata;
  logic [DataWidth-1:0]   rdata_d;
  logic                   sram_we;
  logic                   rd_ok;

  logic                   rsp_valid_q;
  logic [RespWidth-1:0]   rsp_status_q;
  logic [DataWidth-1:0]   rdata_q;

  // --------------------
  // Memories
  // --------------------
  initial begin
    $readmemh("bootrom.hex", rom_mem);
  end

  // ROM wraps every RomWords words
  assign rom_idx   = addr_i.fields.word_idx[RomIdxWidth-1:0];
  assign rom_rdata = rom_mem[rom_idx];

  assign sram_we = valid_i & we_i & (target_i == TgtDram) & (status_i == RespOkay);

  data_sram i_data_sram (
    .clk_i   ( clk_i                  ),
    .we_i    ( sram_we                ),
    .addr_i  ( addr_i.fields.word_idx ),
    .be_i    ( be_i                   ),
    .wdata_i ( wdata_i                ),
    .rdata_o ( sram_rdata             )
  );

  // --------------------
  // Read data select
  // --------------------
  assign rd_ok = valid_i & ~we_i & (status_i == RespOkay);

  always_comb begin
    rdata_d = '0;
    if (rd_ok) begin
      case (target_i)
        TgtRom:  rdata_d = rom_rdata;
        TgtDram: rdata_d = sram_rdata;
        default: rdata_d = '0;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_valid_q  <= 1'b0;
      rsp_status_q <= RespOkay;
    end else begin
      rsp_valid_q  <= valid_i;
      rsp_status_q <= status_i;
    end
  end

  always_ff @(posedge clk_i) begin
    rdata_q <= rdata_d;
  end

  assign rsp_valid_o  = rsp_valid_q;
  assign rsp_status_o = rsp_status_q;
  assign rdata_o      = rdata_q;

  // Decode errors from stage 1 must never carry data
  a_err_zero_data: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
      (rsp_valid_o && (rsp_status_o != RespOkay)) |-> (rdata_o == '0)
  ) else $error("error response with nonzero data");

endmodule

//--- mini_soc.sv
// Top level of the memory-side harness
// Connects the reset generator, the debug gate and the two-stage request
// pipeline. Responses follow requests by two cycles
module mini_soc (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 ndmreset_i,
  input  logic                                 debug_req_i,
  input  logic                                 req_i,
  input  logic                                 we_i,
  input  logic [mini_soc_pkg::AddrWidth-1:0]   addr_i,
  input  logic [mini_soc_pkg::BeWidth-1:0]     be_i,
  input  logic [mini_soc_pkg::DataWidth-1:0]   wdata_i,
  output logic                                 core_rst_no,
  output logic                                 debug_req_o,
  output logic                                 rsp_valid_o,
  output logic [mini_soc_pkg::RespWidth-1:0]   rsp_status_o,
  output logic [mini_soc_pkg::DataWidth-1:0]   rdata_o
);

  import mini_soc_pkg::*;

  // Stage 1 registers
  logic                 s1_valid;
  logic                 s1_we;
  logic [TgtWidth-1:0]  s1_target;
  logic [RespWidth-1:0] s1_status;
  addr_u                s1_addr;
  logic [BeWidth-1:0]   s1_be;
  logic [DataWidth-1:0] s1_wdata;

  // --------------------
  // Reset and debug
  // --------------------
  rst_sync i_rst_sync (
    .clk_i      ( clk_i       ),
    .rst_ni     ( rst_ni      ),
    .ndmreset_i ( ndmreset_i  ),
    .rst_no     ( core_rst_no )
  );

  debug_gate i_debug_gate (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .debug_req_i ( debug_req_i ),
    .debug_req_o ( debug_req_o )
  );

  // --------------------
  // Request pipeline
  // --------------------
  req_decode i_req_decode (
    .clk_i    ( clk_i       ),
    .rst_ni   ( core_rst_no ),
    .req_i    ( req_i       ),
    .we_i     ( we_i        ),
    .addr_i   ( addr_i      ),
    .be_i     ( be_i        ),
    .wdata_i  ( wdata_i     ),
    .valid_o  ( s1_valid    ),
    .we_o     ( s1_we       ),
    .target_o ( s1_target   ),
    .status_o ( s1_status   ),
    .addr_o   ( s1_addr     ),
    .be_o     ( s1_be       ),
    .wdata_o  ( s1_wdata    )
  );

  mem_access i_mem_access (
    .clk_i        ( clk_i        ),
    .rst_ni       ( core_rst_no  ),
    .valid_i      ( s1_valid     ),
    .we_i         ( s1_we        ),
    .target_i     ( s1_target    ),
    .status_i     ( s1_status    ),
    .addr_i       ( s1_addr      ),
    .be_i         ( s1_be        ),
    .wdata_i      ( s1_wdata     ),
    .rsp_valid_o  ( rsp_valid_o  ),
    .rsp_status_o ( rsp_status_o ),
    .rdata_o      ( rdata_o      )
  );

endmodule

//--- tb_mini_soc.sv
// Testbench for the memory-side harness
// Drives requests on the falling edge, predicts each response from the
// address map and checks the outputs with concurrent assertions
module tb_mini_soc;
  timeunit 1ns;
  timeprecision 1ps;

  import mini_soc_pkg::*;

  localparam int unsigned ClkPeriod = 10;
  localparam int unsigned DramOps   = 64;
  localparam int unsigned UnmapOps  = 40;
  localparam int unsigned PoolSize  = 16;
  localparam int unsigned NdmPulse  = 8;
  localparam int unsigned TestCycles = 20 + (RomWords + 10) + (2 * DramOps + 10)
                                     + (UnmapOps + 10) + (DebugHoldCycles + 30)
                                     + (NdmPulse + PoolSize + 20);
  localparam int unsigned WatchdogNs = (TestCycles + 200) * ClkPeriod;

  typedef struct packed {
    logic [31:0]          due;
    logic [RespWidth-1:0] status;
    logic [DataWidth-1:0] rdata;
  } exp_t;

  logic                 clk_i = 1'b1;
  logic                 rst_ni;
  logic                 ndmreset_i;
  logic                 debug_req_i;
  logic                 req_i;
  logic                 we_i;
  logic [AddrWidth-1:0] addr_i;
  logic [BeWidth-1:0]   be_i;
  logic [DataWidth-1:0] wdata_i;
  logic                 core_rst_no;
  logic                 debug_req_o;
  logic                 rsp_valid_o;
  logic [RespWidth-1:0] rsp_status_o;
  logic [DataWidth-1:0] rdata_o;

  // Reference model state
  logic [DataWidth-1:0]    rom_ref [RomWords];
  logic [DataWidth-1:0]    dram_ref [DramWords];
  logic [WordIdxWidth-1:0] pool [PoolSize];
  exp_t                    exp_q [$];
  int unsigned             cyc;
  logic                    exp_valid = 1'b0;
  logic [RespWidth-1:0]    exp_status = RespOkay;
  logic [DataWidth-1:0]    exp_rdata = '0;
  int unsigned             dbg_edges;
  logic                    exp_dbg;
  logic                    rel;

  int unsigned err_cnt;
  int unsigned err_mark;
  int unsigned tests_done;

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  mini_soc dut (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .ndmreset_i   ( ndmreset_i   ),
    .debug_req_i  ( debug_req_i  ),
    .req_i        ( req_i        ),
    .we_i         ( we_i         ),
    .addr_i       ( addr_i       ),
    .be_i         ( be_i         ),
    .wdata_i      ( wdata_i      ),
    .core_rst_no  ( core_rst_no  ),
    .debug_req_o  ( debug_req_o  ),
    .rsp_valid_o  ( rsp_valid_o  ),
    .rsp_status_o ( rsp_status_o ),
    .rdata_o      ( rdata_o      )
  );

  // --------------------
  // Reference model
  // --------------------
  always @(posedge clk_i or negedge rst_ni) begin : ref_model
    logic [RegionWidth-1:0]  region;
    logic [WordIdxWidth-1:0] idx;
    exp_t                    item;
    if (!rst_ni) begin
      exp_valid <= 1'b0;
      exp_q.delete();
      cyc = 0;
    end else begin
      cyc = cyc + 1;
      // Raised one edge ahead so the checks sample it on the due edge
      if (exp_q.size() != 0 && exp_q[0].due == cyc + 1) begin
        exp_valid  <= 1'b1;
        exp_status <= exp_q[0].status;
        exp_rdata  <= exp_q[0].rdata;
        void'(exp_q.pop_front());
      end else begin
        exp_valid <= 1'b0;
      end
      // Requests during ndmreset never reach the pipeline
      if (req_i && !ndmreset_i) begin
        region     = addr_i[AddrWidth-1 -: RegionWidth];
        idx        = addr_i[OffsetWidth +: WordIdxWidth];
        item.due   = cyc + 2;
        item.rdata = '0;
        if (region == RomRegion) begin
          item.status = we_i ? RespSlvErr : RespOkay;
          if (!we_i) begin
            item.rdata = rom_ref[idx % RomWords];
          end
        end else if (region == DramRegion) begin
          item.status = RespOkay;
          if (we_i) begin
            for (int b = 0; b < BeWidth; b++) begin
              if (be_i[b]) begin
                dram_ref[idx][b*8 +: 8] = wdata_i[b*8 +: 8];
              end
            end
          end else begin
            item.rdata = dram_ref[idx];
          end
        end else begin
          item.status = RespDecErr;
        end
        exp_q.push_back(item);
      end
    end
  end

  // Edges seen since power-on reset, saturating at the boot window
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dbg_edges <= 0;
    end else if (dbg_edges < DebugHoldCycles) begin
      dbg_edges <= dbg_edges + 1;
    end
  end

  assign exp_dbg = (dbg_edges >= DebugHoldCycles) ? debug_req_i : 1'b0;
  assign rel     = rst_ni & ~ndmreset_i;

  // --------------------
  // Checks
  // --------------------
  a_rsp_valid: assert property (@(posedge clk_i) rsp_valid_o === exp_valid)
    else flag_error($sformatf("rsp_valid_o is %0b, expected %0b",
                              $sampled(rsp_valid_o), $sampled(exp_valid)));

  a_rsp_data: assert property (@(posedge clk_i)
      exp_valid |-> (rsp_status_o === exp_status && rdata_o === exp_rdata))
    else flag_error($sformatf("response %0d/%h, expected %0d/%h",
                              $sampled(rsp_status_o), $sampled(rdata_o),
                              $sampled(exp_status), $sampled(exp_rdata)));

  a_core_held: assert property (@(posedge clk_i) !rel |-> !core_rst_no)
    else flag_error("core_rst_no high while reset is requested");

  a_core_release: assert property (@(posedge clk_i)
      $rose(rel) |-> !core_rst_no ##1 !core_rst_no ##1 core_rst_no)
    else flag_error("core_rst_no not released on second edge after reset");

  a_no_rsp_in_reset: assert property (@(posedge clk_i) !core_rst_no |-> !rsp_valid_o)
    else flag_error("response while core is in reset");

  a_debug_gate: assert property (@(posedge clk_i) debug_req_o === exp_dbg)
    else flag_error($sformatf("debug_req_o is %0b, expected %0b after %0d edges",
                              $sampled(debug_req_o), $sampled(exp_dbg),
                              $sampled(dbg_edges)));

  // --------------------
  // Helpers
  // --------------------
  task automatic flag_error(input string msg);
    err_cnt++;
    $display("error %0t ns: %s", $time, msg);
  endtask

  task automatic issue(input logic we, input logic [AddrWidth-1:0] addr,
                       input logic [BeWidth-1:0] be, input logic [DataWidth-1:0] wdata);
    @(negedge clk_i);
    req_i   = 1'b1;
    we_i    = we;
    addr_i  = addr;
    be_i    = be;
    wdata_i = wdata;
  endtask

  task automatic idle(input int unsigned n);
    repeat (n) begin
      @(negedge clk_i);
      req_i = 1'b0;
      we_i  = 1'b0;
    end
  endtask

  task automatic end_test(input string name);
    tests_done++;
    $display("test %s done, %0d errors", name, err_cnt - err_mark);
    err_mark = err_cnt;
  endtask

  function automatic logic [DataWidth-1:0] rand64();
    return {$urandom, $urandom};
  endfunction

  function automatic logic [AddrWidth-1:0] dram_addr(input logic [WordIdxWidth-1:0] idx);
    return {DramRegion, idx, OffsetWidth'($urandom)};
  endfunction

  // --------------------
  // Tests
  // --------------------
  task automatic rom_test();
    int unsigned w;
    for (int i = 0; i < RomWords; i++) begin
      issue(1'b0, RomBase + i * 8 + ($urandom % 8), '0, '0);
    end
    w = $urandom % RomWords;
    issue(1'b1, RomBase + w * 8, '1, rand64());
    issue(1'b0, RomBase + w * 8, '0, '0);
    idle(3);
  endtask

  task automatic dram_test();
    logic [WordIdxWidth-1:0] idx;
    for (int i = 0; i < DramOps; i++) begin
      idx = pool[$urandom % PoolSize];
      issue(1'b1, dram_addr(idx), BeWidth'($urandom), rand64());
      issue(1'b0, dram_addr(idx), '0, '0);
    end
    idle(3);
  endtask

  task automatic unmapped_test();
    logic [AddrWidth-1:0] addr;
    for (int i = 0; i < UnmapOps; i++) begin
      addr = $urandom;
      while (addr[AddrWidth-1 -: RegionWidth] == RomRegion ||
             addr[AddrWidth-1 -: RegionWidth] == DramRegion) begin
        addr = $urandom;
      end
      issue(1'($urandom), addr, BeWidth'($urandom), rand64());
    end
    idle(3);
  endtask

  task automatic debug_test();
    wait (dbg_edges >= DebugHoldCycles);
    repeat (20) begin
      @(negedge clk_i);
      debug_req_i = 1'($urandom);
    end
  endtask

  task automatic ndmreset_test();
    @(negedge clk_i);
    ndmreset_i = 1'b1;
    // Writes in the pulse are dropped, so old data must survive
    for (int k = 0; k < NdmPulse; k++) begin
      issue(1'b1, dram_addr(pool[k % PoolSize]), '1, rand64());
      debug_req_i = 1'($urandom);
    end
    @(negedge clk_i);
    req_i      = 1'b0;
    ndmreset_i = 1'b0;
    wait (core_rst_no === 1'b1);
    for (int k = 0; k < PoolSize; k++) begin
      issue(1'b0, dram_addr(pool[k]), '0, '0);
    end
    idle(3);
  endtask

  initial begin
    #(WatchdogNs);
    $display("watchdog: run did not finish within %0d ns, stopping", WatchdogNs);
    $display("Finished with errors");
    $finish;
  end

  initial begin
    void'($urandom(32'hc655));
    rst_ni      = 1'b1;
    ndmreset_i  = 1'b0;
    debug_req_i = 1'b1;
    req_i       = 1'b0;
    we_i        = 1'b0;
    addr_i      = '0;
    be_i        = '0;
    wdata_i     = '0;
    err_cnt     = 0;
    err_mark    = 0;
    tests_done  = 0;
    $readmemh("bootrom.hex", rom_ref);
    for (int i = 0; i < PoolSize; i++) begin
      pool[i] = WordIdxWidth'($urandom);
    end

    @(negedge clk_i);
    rst_ni = 1'b0;
    repeat (10) @(negedge clk_i);
    rst_ni = 1'b1;
    wait (core_rst_no === 1'b1);
    end_test("reset");

    rom_test();
    end_test("rom");
    dram_test();
    end_test("dram");
    unmapped_test();
    end_test("unmapped");
    debug_test();
    end_test("debug gate");
    ndmreset_test();
    end_test("ndmreset");

    if (exp_q.size() != 0) begin
      err_cnt++;
      $display("%0d expected responses never arrived", exp_q.size());
    end
    $display("tests %0d, errors %0d", tests_done, err_cnt);
    if (err_cnt == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

//--- bootrom.hex
// One 64-bit boot ROM word per line, word index 0 to 31
// Upper half is the byte address of the word, lower half its complement
00010000fffeffff
00010008fffefff7
00010010fffeffef
00010018fffeffe7
00010020fffeffdf
00010028fffeffd7
00010030fffeffcf
00010038fffeffc7
00010040fffeffbf
00010048fffeffb7
00010050fffeffaf
00010058fffeffa7
00010060fffeff9f
00010068fffeff97
00010070fffeff8f
00010078fffeff87
00010080fffeff7f
00010088fffeff77
00010090fffeff6f
00010098fffeff67
000100a0fffeff5f
000100a8fffeff57
000100b0fffeff4f
000100b8fffeff47
000100c0fffeff3f
000100c8fffeff37
000100d0fffeff2f
000100d8fffeff27
000100e0fffeff1f
000100e8fffeff17
000100f0fffeff0f
000100f8fffeff07

//--- mini_soc.f
mini_soc_pkg.sv
rst_sync.sv
debug_gate.sv
req_decode.sv
data_sram.sv
mem_access.sv
mini_soc.sv
tb_mini_soc.sv

//--- Bender.yml
package:
  name: mini_soc

sources:
  - mini_soc_pkg.sv
  - rst_sync.sv
  - debug_gate.sv
  - req_decode.sv
  - data_sram.sv
  - mem_access.sv
  - mini_soc.sv
  - target: simulation
    files:
      - tb_mini_soc.sv
